// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= rv32v_memory_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_MSG  := TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== list.f ====
+incdir+source
source/rv32v_types_pkg.sv
source/address_scheduler.sv
source/data_cache_model.sv
source/rv32v_memory_stage.sv
source/rv32v_memory_top.sv
verification/rv32v_memory_props.sv
verification/rv32v_memory_tb.sv

// ==== source/address_scheduler.sv ====
`default_nettype none

`include "rv32v_settings.svh"

module address_scheduler (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv32v_types_pkg::word_t     addr0,
  input  rv32v_types_pkg::word_t     addr1,
  input  rv32v_types_pkg::word_t     storedata0,
  input  rv32v_types_pkg::word_t     storedata1,
  input  rv32v_types_pkg::sew_t      sew,
  input  logic                       load,
  input  logic                       store,
  input  logic                       dhit,
  input  logic                       returnex,
  output rv32v_types_pkg::word_t     final_addr,
  output rv32v_types_pkg::word_t     final_storedata,
  output rv32v_types_pkg::byte_ena_t byte_ena,
  output logic                       ren,
  output logic                       wen,
  output logic                       busy,
  output logic                       exception,
  output logic                       arrived0
);

  rv32v_types_pkg::as_state_t state, next_state;
  rv32v_types_pkg::word_t     lane_addr, lane_data;
  logic ignore_req;  // Request still held from the access just finished
  logic req, in_lane, misaligned, lane1_sel;

  // Element alignment check for one address
  function automatic logic is_misaligned(input rv32v_types_pkg::word_t a,
                                         input rv32v_types_pkg::sew_t s);
    case (s)
      rv32v_types_pkg::SEW8:  is_misaligned = 1'b0;
      rv32v_types_pkg::SEW16: is_misaligned = a[0];
      default:                is_misaligned = |a[1:0];  // SEW32 and unused codes
    endcase
  endfunction

  assign req        = (load | store) & ~ignore_req;
  assign misaligned = is_misaligned(addr0, sew) | is_misaligned(addr1, sew);
  assign in_lane    = (state == rv32v_types_pkg::LANE0) || (state == rv32v_types_pkg::LANE1);

  // Lane 1 from its own state through DONE, so the latch sees its word
  assign lane1_sel = (state == rv32v_types_pkg::LANE1) || (state == rv32v_types_pkg::DONE);
  assign lane_addr = lane1_sel ? addr1 : addr0;
  assign lane_data = lane1_sel ? storedata1 : storedata0;

  assign final_addr      = {lane_addr[`RV32V_WORD_W-1:2], 2'b00};  // Word aligned
  assign final_storedata = lane_data << {lane_addr[1:0], 3'b000};  // Into addressed bytes

  always_comb begin
    case (sew)
      rv32v_types_pkg::SEW8:  byte_ena = rv32v_types_pkg::byte_ena_t'(1) << lane_addr[1:0];
      rv32v_types_pkg::SEW16: byte_ena = rv32v_types_pkg::byte_ena_t'(3) << {lane_addr[1], 1'b0};
      default:                byte_ena = '1;
    endcase
  end

  // Load wins if both strobes are up
  assign ren = in_lane & load;
  assign wen = in_lane & store & ~load;

  // Busy from the request cycle on, low again in DONE
  assign busy      = in_lane || ((state == rv32v_types_pkg::IDLE) && req && !misaligned);
  assign exception = (state == rv32v_types_pkg::EXCEPT);
  assign arrived0  = (state == rv32v_types_pkg::LANE0) && dhit;  // Lane 0 data valid

  always_comb begin
    next_state = state;
    case (state)
      rv32v_types_pkg::IDLE: begin
        if (req) begin
          next_state = misaligned ? rv32v_types_pkg::EXCEPT : rv32v_types_pkg::LANE0;
        end
      end
      rv32v_types_pkg::LANE0:  if (dhit) next_state = rv32v_types_pkg::LANE1;
      rv32v_types_pkg::LANE1:  if (dhit) next_state = rv32v_types_pkg::DONE;
      rv32v_types_pkg::DONE:   next_state = rv32v_types_pkg::IDLE;  // Latch takes result here
      rv32v_types_pkg::EXCEPT: if (returnex) next_state = rv32v_types_pkg::IDLE;
      default:                 next_state = rv32v_types_pkg::IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state      <= rv32v_types_pkg::IDLE;
      ignore_req <= 1'b0;
    end else begin
      state <= next_state;
      // Skip one IDLE cycle so the execute stage can move on
      ignore_req <= (state == rv32v_types_pkg::DONE) ||
                    ((state == rv32v_types_pkg::EXCEPT) && returnex);
    end
  end

endmodule

`default_nettype wire

// ==== source/data_cache_model.sv ====
`default_nettype none

`include "rv32v_settings.svh"

module data_cache_model (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv32v_types_pkg::word_t     dmemaddr,
  input  rv32v_types_pkg::word_t     dmemstore,
  input  rv32v_types_pkg::byte_ena_t byte_ena,
  input  logic                       ren,
  input  logic                       wen,
  output rv32v_types_pkg::word_t     dmemload,
  output logic                       dhit
);

  localparam int IDX_W  = $clog2(`RV32V_DMEM_WORDS);
  localparam int CNT_W  = (`RV32V_DCACHE_LAT > 1) ? $clog2(`RV32V_DCACHE_LAT) : 1;
  localparam int NBYTES = `RV32V_WORD_W / 8;

  rv32v_types_pkg::word_t mem [`RV32V_DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [CNT_W-1:0] cnt;  // Cycles already spent on this access
  logic             access;

  assign idx    = dmemaddr[IDX_W+1:2];  // Wraps modulo depth
  assign access = ren | wen;

  // Hit in the last cycle of the access
  assign dhit     = access && (cnt == CNT_W'(`RV32V_DCACHE_LAT - 1));
  assign dmemload = mem[idx];  // Addressed word, valid at dhit

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
    end else if (!access || dhit) begin
      cnt <= '0;  // Back to back accesses restart here
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Byte merge on write hit
  always_ff @(posedge CLK) begin
    if (wen && dhit) begin
      for (int i = 0; i < NBYTES; i++) begin
        if (byte_ena[i]) mem[idx][8*i +: 8] <= dmemstore[8*i +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rv32v_memory_stage.sv ====
`default_nettype none

module rv32v_memory_stage (
  input  logic                       CLK, nRST, returnex, stall_mem, flush_mem,
  input  rv32v_types_pkg::word_t     aluresult0, aluresult1,
  input  rv32v_types_pkg::word_t     storedata0, storedata1,
  input  rv32v_types_pkg::word_t     vl_in, vtype_in, dmemload,
  input  logic                       load, store, config_type,
  input  logic                       wen0_in, wen1_in, dhit,
  input  rv32v_types_pkg::woffset_t  woffset0_in, woffset1_in,
  output rv32v_types_pkg::word_t     wdat0, wdat1,
  output rv32v_types_pkg::word_t     dmemaddr, dmemstore, vl,
  output logic                       wen0, wen1, ren, wen,
  output logic                       busy_mem, exception_mem, vill,
  output rv32v_types_pkg::woffset_t  woffset0, woffset1,
  output rv32v_types_pkg::byte_ena_t byte_ena,
  output rv32v_types_pkg::sew_t      sew,
  output rv32v_types_pkg::vlmul_t    lmul
);

  rv32v_types_pkg::word_t load_buf;    // Lane 0 element, already aligned
  rv32v_types_pkg::word_t lane1_data;
  rv32v_types_pkg::word_t wdat0_n, wdat1_n;
  rv32v_types_pkg::word_t vtype;
  logic arrived0;

  // Element to bit 0, zero extended to SEW
  function automatic rv32v_types_pkg::word_t align_load(input rv32v_types_pkg::word_t w,
                                                        input logic [1:0] off,
                                                        input rv32v_types_pkg::sew_t s);
    rv32v_types_pkg::word_t shifted;
    shifted = w >> {off, 3'b000};
    case (s)
      rv32v_types_pkg::SEW8:  align_load = rv32v_types_pkg::word_t'(shifted[7:0]);
      rv32v_types_pkg::SEW16: align_load = rv32v_types_pkg::word_t'(shifted[15:0]);
      default:                align_load = shifted;
    endcase
  endfunction

  address_scheduler sched (
    .CLK             (CLK),
    .nRST            (nRST),
    .addr0           (aluresult0),
    .addr1           (aluresult1),
    .storedata0      (storedata0),
    .storedata1      (storedata1),
    .sew             (sew),          // From CSR
    .load            (load),
    .store           (store),
    .dhit            (dhit),
    .returnex        (returnex),
    .final_addr      (dmemaddr),
    .final_storedata (dmemstore),
    .byte_ena        (byte_ena),
    .ren             (ren),
    .wen             (wen),
    .busy            (busy_mem),
    .exception       (exception_mem),
    .arrived0        (arrived0)
  );

  // Lane 0 arrives first, hold it until lane 1 is done
  always_ff @(posedge CLK) begin
    if (arrived0) load_buf <= align_load(dmemload, aluresult0[1:0], sew);
  end

  assign lane1_data = align_load(dmemload, aluresult1[1:0], sew);  // Valid in DONE
  assign wdat0_n    = load ? load_buf : aluresult0;
  assign wdat1_n    = load ? lane1_data : aluresult1;

  // Writeback latch, flush over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wdat0 <= '0;
      wdat1 <= '0;
      wen0 <= 1'b0;
      wen1 <= 1'b0;
      woffset0 <= '0;
      woffset1 <= '0;
    end else if (flush_mem) begin
      wdat0 <= '0;
      wdat1 <= '0;
      wen0 <= 1'b0;
      wen1 <= 1'b0;
      woffset0 <= '0;
      woffset1 <= '0;
    end else if (!stall_mem) begin
      wdat0 <= wdat0_n;
      wdat1 <= wdat1_n;
      wen0 <= wen0_in;
      wen1 <= wen1_in;
      woffset0 <= woffset0_in;
      woffset1 <= woffset1_in;
    end
  end

  // vl and vtype, written by config instructions
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl    <= '0;
      vtype <= '0;  // SEW8 out of reset
    end else if (config_type) begin
      vl    <= vl_in;
      vtype <= vtype_in;
    end
  end

  assign sew  = rv32v_types_pkg::sew_t'(vtype[2:0]);
  assign lmul = rv32v_types_pkg::vlmul_t'(vtype[5:3]);
  assign vill = vtype[31];  // Illegal config flag

endmodule

`default_nettype wire

// ==== source/rv32v_memory_top.sv ====
`default_nettype none

module rv32v_memory_top (
  input  logic                      CLK, nRST,
  // Execute stage
  input  rv32v_types_pkg::word_t    aluresult0, aluresult1,
  input  rv32v_types_pkg::word_t    storedata0, storedata1,
  input  logic                      load, store,
  input  logic                      wen0_in, wen1_in,
  input  rv32v_types_pkg::woffset_t woffset0_in, woffset1_in,
  input  logic                      config_type,
  input  rv32v_types_pkg::word_t    vl_in, vtype_in,
  // Hazard unit
  input  logic                      stall_mem, flush_mem, returnex,
  output logic                      busy_mem, exception_mem,
  // Writeback
  output rv32v_types_pkg::word_t    wdat0, wdat1,
  output logic                      wen0, wen1,
  output rv32v_types_pkg::woffset_t woffset0, woffset1,
  // CSR view
  output rv32v_types_pkg::word_t    vl,
  output rv32v_types_pkg::sew_t     sew,
  output rv32v_types_pkg::vlmul_t   lmul,
  output logic                      vill
);

  // Stage to cache
  rv32v_types_pkg::word_t     dmemaddr, dmemstore, dmemload;
  rv32v_types_pkg::byte_ena_t byte_ena;
  logic                       ren, wen, dhit;

  rv32v_memory_stage mem_stage (
    .CLK(CLK), .nRST(nRST), .returnex(returnex),
    .stall_mem(stall_mem), .flush_mem(flush_mem),
    .aluresult0(aluresult0), .aluresult1(aluresult1),
    .storedata0(storedata0), .storedata1(storedata1),
    .vl_in(vl_in), .vtype_in(vtype_in), .dmemload(dmemload),
    .load(load), .store(store), .config_type(config_type),
    .wen0_in(wen0_in), .wen1_in(wen1_in), .dhit(dhit),
    .woffset0_in(woffset0_in), .woffset1_in(woffset1_in),
    .wdat0(wdat0), .wdat1(wdat1),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .vl(vl),
    .wen0(wen0), .wen1(wen1), .ren(ren), .wen(wen),
    .busy_mem(busy_mem), .exception_mem(exception_mem), .vill(vill),
    .woffset0(woffset0), .woffset1(woffset1),
    .byte_ena(byte_ena), .sew(sew), .lmul(lmul)
  );

  // Fixed latency stand-in for the data cache
  data_cache_model dcache (
    .CLK(CLK), .nRST(nRST),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .byte_ena(byte_ena),
    .ren(ren), .wen(wen),
    .dmemload(dmemload), .dhit(dhit)
  );

endmodule

`default_nettype wire

// ==== source/rv32v_settings.svh ====
`ifndef RV32V_SETTINGS_SVH
`define RV32V_SETTINGS_SVH

// Data and address width
`define RV32V_WORD_W 32

// Cache model depth in words
// Word index is addr[..:2] modulo this depth
`define RV32V_DMEM_WORDS 256

// Cycles from access start to dhit, dhit included
`define RV32V_DCACHE_LAT 2

// Vector register length in bytes
`define RV32V_VLENB 16

`endif

// ==== source/rv32v_types_pkg.sv ====
`default_nettype none

`include "rv32v_settings.svh"

package rv32v_types_pkg;

  typedef logic [`RV32V_WORD_W-1:0]   word_t;      // Data or address word
  typedef logic [`RV32V_WORD_W/8-1:0] byte_ena_t;  // One bit per byte lane
  typedef logic [4:0]                 woffset_t;   // Writeback register offset

  // Element width, codes above SEW32 behave as SEW32
  typedef enum logic [2:0] {
    SEW8  = 3'd0,
    SEW16 = 3'd1,
    SEW32 = 3'd2
  } sew_t;

  // Register group multiplier, vtype[5:3]
  typedef enum logic [2:0] {
    LMUL1     = 3'd0,
    LMUL2     = 3'd1,
    LMUL4     = 3'd2,
    LMUL8     = 3'd3,
    LMUL_RSVD = 3'd4,
    LMUL_F8   = 3'd5,  // Fractional
    LMUL_F4   = 3'd6,
    LMUL_F2   = 3'd7
  } vlmul_t;

  // Address scheduler FSM
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    LANE0  = 3'd1,
    LANE1  = 3'd2,
    DONE   = 3'd3,
    EXCEPT = 3'd4   // Misaligned element, wait for returnex
  } as_state_t;

endpackage

`default_nettype wire

// ==== verification/rv32v_memory_props.sv ====
`default_nettype none

`include "rv32v_settings.svh"

module rv32v_memory_props (
  input logic                       CLK,
  input logic                       nRST,
  input logic                       ren,
  input logic                       wen,
  input logic                       dhit,
  input logic                       busy,
  input logic                       exception,
  input rv32v_types_pkg::as_state_t state
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned failures = 0;  // Summed up by the testbench

  // Cache answers only an open access
  dhit_in_access: assert property (@(posedge CLK) disable iff (!nRST) dhit |-> (ren || wen))
    else begin
      $error("dhit seen with neither ren nor wen high");
      failures++;
    end

  read_xor_write: assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen))
    else begin
      $error("ren and wen high together");
      failures++;
    end

  idle_on_except: assert property (@(posedge CLK) disable iff (!nRST) exception |-> !busy)
    else begin
      $error("busy high during exception");
      failures++;
    end

  // Accepted request, lane 0 hit after the cache latency
  lane0_latency: assert property (@(posedge CLK) disable iff (!nRST)
    ((state == rv32v_types_pkg::IDLE) && busy) |-> ##`RV32V_DCACHE_LAT dhit)
    else begin
      $error("lane 0 dhit did not come after the cache latency");
      failures++;
    end

  ren_held: assert property (@(posedge CLK) disable iff (!nRST) (ren && !dhit) |=> ren)
    else begin
      $error("ren dropped before dhit");
      failures++;
    end

  wen_held: assert property (@(posedge CLK) disable iff (!nRST) (wen && !dhit) |=> wen)
    else begin
      $error("wen dropped before dhit");
      failures++;
    end

endmodule

bind address_scheduler rv32v_memory_props props (
  .CLK(CLK), .nRST(nRST), .ren(ren), .wen(wen), .dhit(dhit),
  .busy(busy), .exception(exception), .state(state)
);

`default_nettype wire

// ==== verification/rv32v_memory_tb.sv ====
`default_nettype none

`include "rv32v_settings.svh"

module rv32v_memory_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD_NS   = 100;
  localparam int RESET_CYC   = 16;
  localparam int N_RANDOM    = 240;  // Random ops after the fill
  localparam int N_OPS       = 400;  // Fill plus random, rounded up
  localparam int CYC_PER_OP  = 8;
  localparam int WATCHDOG_NS = (N_OPS * CYC_PER_OP + RESET_CYC) * PERIOD_NS;
  localparam int MEM_BYTES   = `RV32V_DMEM_WORDS * 4;
  localparam int BA_W        = $clog2(MEM_BYTES);

  logic CLK = 1'b0;
  logic nRST, load, store, wen0_in, wen1_in, config_type;
  logic stall_mem, flush_mem, returnex, hold_latch;
  logic busy_mem, exception_mem, wen0, wen1, vill;
  rv32v_types_pkg::word_t    aluresult0, aluresult1, storedata0, storedata1;
  rv32v_types_pkg::word_t    vl_in, vtype_in, wdat0, wdat1, vl;
  rv32v_types_pkg::woffset_t woffset0_in, woffset1_in, woffset0, woffset1;
  rv32v_types_pkg::sew_t     sew;
  rv32v_types_pkg::vlmul_t   lmul;

  logic [7:0]  model_mem [MEM_BYTES];  // Byte image of the cache
  logic [31:0] m_vtype, m_vl;
  logic [31:0] rng = 32'h58d2_45ee;
  int          errors = 0;
  int          checks = 0;
  int          prop_fails;

  rv32v_memory_top DUT (.*);

  always #(PERIOD_NS / 2) CLK = ~CLK;

  assign stall_mem = busy_mem | hold_latch;  // Hazard unit role

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Element size in bytes, unused codes act as SEW32
  function automatic int sew_bytes(input logic [2:0] code);
    case (code)
      3'd0:    return 1;
      3'd1:    return 2;
      default: return 4;
    endcase
  endfunction

  function automatic rv32v_types_pkg::word_t model_load(input rv32v_types_pkg::word_t a);
    rv32v_types_pkg::word_t v;
    logic [BA_W-1:0] b;
    v = '0;  // Zero extension above SEW
    b = a[BA_W-1:0];
    for (int k = 0; k < sew_bytes(m_vtype[2:0]); k++) begin
      v[8*k +: 8] = model_mem[b + BA_W'(k)];
    end
    return v;
  endfunction

  function automatic void model_store(input rv32v_types_pkg::word_t a,
                                      input rv32v_types_pkg::word_t d);
    logic [BA_W-1:0] b;
    b = a[BA_W-1:0];
    for (int k = 0; k < sew_bytes(m_vtype[2:0]); k++) begin
      model_mem[b + BA_W'(k)] = d[8*k +: 8];  // Low SEW bytes of store data
    end
  endfunction

  function automatic rv32v_types_pkg::word_t fill_word(input rv32v_types_pkg::word_t a);
    return a * 32'h9e37_79b9;  // Odd multiplier, every address bit counts
  endfunction

  function automatic rv32v_types_pkg::word_t random_vtype();
    logic [31:0] r;
    r = next_rand();
    return {r[31], 25'd0, r[5:3], r[8] & r[9], r[1:0]};  // vill, lmul, sew
  endfunction

  task automatic check_val(input string name, input rv32v_types_pkg::word_t got,
                           input rv32v_types_pkg::word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_latch(input rv32v_types_pkg::word_t e0, input rv32v_types_pkg::word_t e1,
                             input logic w0, input logic w1,
                             input rv32v_types_pkg::woffset_t o0,
                             input rv32v_types_pkg::woffset_t o1);
    check_val("wdat0", wdat0, e0);
    check_val("wdat1", wdat1, e1);
    check_val("wen0", 32'(wen0), 32'(w0));
    check_val("wen1", 32'(wen1), 32'(w1));
    check_val("woffset0", 32'(woffset0), 32'(o0));
    check_val("woffset1", 32'(woffset1), 32'(o1));
  endtask

  task automatic randomize_wb();
    logic [31:0] r;
    r = next_rand();
    wen0_in = r[0];
    wen1_in = r[1];
    woffset0_in = r[6:2];
    woffset1_in = r[11:7];
  endtask

  task automatic alu_op();
    load = 1'b0;
    store = 1'b0;
    aluresult0 = next_rand();
    aluresult1 = next_rand();
    randomize_wb();
    @(negedge CLK);
    check_latch(aluresult0, aluresult1, wen0_in, wen1_in, woffset0_in, woffset1_in);
  endtask

  task automatic flush_op();
    alu_op();
    flush_mem = 1'b1;
    aluresult0 = next_rand();
    @(negedge CLK);
    flush_mem = 1'b0;
    check_latch('0, '0, 1'b0, 1'b0, '0, '0);  // Latch cleared
  endtask

  task automatic stall_op();
    rv32v_types_pkg::word_t e0, e1;
    logic w0, w1;
    rv32v_types_pkg::woffset_t o0, o1;
    alu_op();
    e0 = aluresult0;
    e1 = aluresult1;
    w0 = wen0_in;
    w1 = wen1_in;
    o0 = woffset0_in;
    o1 = woffset1_in;
    hold_latch = 1'b1;  // Stall with busy low
    aluresult0 = next_rand();
    aluresult1 = next_rand();
    randomize_wb();
    repeat (2) @(negedge CLK);
    check_latch(e0, e1, w0, w1, o0, o1);
    hold_latch = 1'b0;
  endtask

  task automatic config_op(input rv32v_types_pkg::word_t vt);
    config_type = 1'b1;
    vl_in = next_rand() % (`RV32V_VLENB * 8 + 1);
    vtype_in = vt;
    @(negedge CLK);
    config_type = 1'b0;
    m_vl = vl_in;
    m_vtype = vt;
    check_val("vl", vl, m_vl);
    check_val("sew", 32'(sew), 32'(vt[2:0]));
    check_val("lmul", 32'(lmul), 32'(vt[5:3]));
    check_val("vill", 32'(vill), 32'(vt[31]));
  endtask

  // Two-lane access, held until the DONE cycle
  task automatic mem_access(input logic is_load, input rv32v_types_pkg::word_t a0,
                            input rv32v_types_pkg::word_t a1,
                            input rv32v_types_pkg::word_t d0,
                            input rv32v_types_pkg::word_t d1);
    rv32v_types_pkg::word_t exp0, exp1;
    logic seen;
    seen = 1'b0;
    exp0 = is_load ? model_load(a0) : a0;  // Stores pass ALU results
    exp1 = is_load ? model_load(a1) : a1;
    load = is_load;
    store = !is_load;
    aluresult0 = a0;
    aluresult1 = a1;
    storedata0 = d0;
    storedata1 = d1;
    randomize_wb();
    for (int n = 0; n < 20; n++) begin
      @(negedge CLK);
      if (busy_mem) seen = 1'b1;
      else if (seen) break;  // DONE cycle
    end
    assert (seen && !busy_mem) else begin
      errors++;
      $display("%0t: access to %h and %h never completed", $time, a0, a1);
    end
    @(negedge CLK);  // Latched at the end of DONE
    check_latch(exp0, exp1, wen0_in, wen1_in, woffset0_in, woffset1_in);
    if (!is_load) begin
      model_store(a0, d0);
      model_store(a1, d1);  // Lane 1 last, wins on collision
    end
    load = 1'b0;
    store = 1'b0;
    @(negedge CLK);
  endtask

  task automatic random_access(input logic is_load);
    rv32v_types_pkg::word_t mask, a0, a1, r;
    mask = ~rv32v_types_pkg::word_t'(sew_bytes(m_vtype[2:0]) - 1);
    r = next_rand();
    a0 = next_rand() & mask;
    a1 = next_rand() & mask;
    if (r[3:0] == 4'd0) a1 = a0;                               // Forced lane collision
    else if (r[3:0] == 4'd1) a1 = {a0[31:2], r[5:4]} & mask;  // Same word, other element
    mem_access(is_load, a0, a1, next_rand(), next_rand());
  endtask

  task automatic misalign_op();
    rv32v_types_pkg::word_t mask, a0, a1, r;
    if (sew_bytes(m_vtype[2:0]) == 1) config_op(32'h0000_0009);  // SEW16, LMUL2
    mask = ~rv32v_types_pkg::word_t'(sew_bytes(m_vtype[2:0]) - 1);
    r = next_rand();
    a0 = next_rand() & mask;
    a1 = next_rand() & mask;
    if (r[0]) a0 = a0 | 32'd1;
    else a1 = a1 | 32'd1;
    store = 1'b1;
    aluresult0 = a0;
    aluresult1 = a1;
    storedata0 = next_rand();
    storedata1 = next_rand();
    repeat (2) begin
      @(negedge CLK);
      check_val("exception_mem", 32'(exception_mem), 32'd1);
      check_val("busy_mem", 32'(busy_mem), 32'd0);
    end
    returnex = 1'b1;
    store = 1'b0;
    @(negedge CLK);
    returnex = 1'b0;
    check_val("exception_mem", 32'(exception_mem), 32'd0);
    @(negedge CLK);
    // Word of the rejected store must be untouched
    a0 = {a0[31:2], 2'b00};
    mem_access(1'b1, a0, a0, '0, '0);
  endtask

  initial begin
    nRST = 1'b0;
    {load, store, wen0_in, wen1_in, config_type} = '0;
    {flush_mem, returnex, hold_latch} = '0;
    {aluresult0, aluresult1, storedata0, storedata1, vl_in, vtype_in} = '0;
    {woffset0_in, woffset1_in} = '0;
    m_vtype = '0;
    m_vl = '0;
    repeat (RESET_CYC) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    config_op(32'h0000_0002);  // SEW32 for the fill
    for (int w = 0; w < `RV32V_DMEM_WORDS; w += 2) begin
      mem_access(1'b0, 32'(4 * w), 32'(4 * w + 4),
                 fill_word(32'(4 * w)), fill_word(32'(4 * w + 4)));
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      case (next_rand() & 32'hf)
        0, 1, 2:     alu_op();
        3, 4, 5, 6:  random_access(1'b0);
        11:          misalign_op();
        12:          flush_op();
        13:          config_op(random_vtype());
        14:          stall_op();
        default:     random_access(1'b1);
      endcase
    end
    prop_fails = int'(DUT.mem_stage.sched.props.failures);
    $display("checks %0d errors %0d property failures %0d", checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the op budget
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
